// ==== hdl/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    // RV32I major opcodes
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_SYSTEM = 7'b1110011,
        OPC_FENCE  = 7'b0001111
    } opcode_e;

    typedef enum logic [2:0] {
        IMM_I = 3'd0,
        IMM_S = 3'd1,
        IMM_B = 3'd2,
        IMM_U = 3'd3,
        IMM_J = 3'd4  // JAL offset
    } imm_type_e;

    typedef enum logic [4:0] {
        ALU_ADD   = 5'b00000,
        ALU_SUB   = 5'b00001,
        ALU_SLL   = 5'b00010,
        ALU_SLT   = 5'b00011,
        ALU_SLTU  = 5'b00100,
        ALU_XOR   = 5'b00101,
        ALU_SRL   = 5'b00110,
        ALU_SRA   = 5'b00111,
        ALU_OR    = 5'b01000,
        ALU_AND   = 5'b01001,
        ALU_LUI   = 5'b01010,
        ALU_AUIPC = 5'b01011,
        ALU_EQ    = 5'b01100,
        ALU_NE    = 5'b01101,
        ALU_LT    = 5'b01110,
        ALU_GE    = 5'b01111,
        ALU_LTU   = 5'b10000,
        ALU_GEU   = 5'b10001
    } alu_op_e;

    typedef struct packed {
        logic      reg_write;
        logic      mem_read;
        logic      mem_write;
        logic      alu_src;    // Operand b from immediate
        logic      branch;
        logic      jump;
        logic      jalr;
        logic      lui;
        logic      auipc;
        logic      system;
        alu_op_e   alu_op;
        imm_type_e imm_type;
    } ctrl_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] next_pc;
        logic [4:0]  rd;
        logic        rd_we;
        logic [31:0] rd_data;
        logic        mem_read;
        logic        mem_write;
        logic [31:0] mem_addr;
        logic [31:0] store_data;
        logic        taken;
    } retire_t;

endpackage

`default_nettype wire

// ==== hdl/control_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module control_unit (
    input  logic [31:0]   inst,
    input  logic          inst_valid,
    output rv_pkg::ctrl_t ctrl,
    output logic [4:0]    rd,
    output logic [4:0]    rs1,
    output logic [4:0]    rs2,
    output logic [2:0]    funct3
);

    rv_pkg::opcode_e opcode;
    logic            funct7_b5;

    assign opcode    = rv_pkg::opcode_e'(inst[6:0]);
    assign rd        = inst[11:7];
    assign funct3    = inst[14:12];
    assign rs1       = inst[19:15];
    assign rs2       = inst[24:20];
    assign funct7_b5 = inst[30];  // SUB / SRA select

    always_comb begin
        ctrl.reg_write = 1'b0;
        ctrl.mem_read  = 1'b0;
        ctrl.mem_write = 1'b0;
        ctrl.alu_src   = 1'b0;
        ctrl.branch    = 1'b0;
        ctrl.jump      = 1'b0;
        ctrl.jalr      = 1'b0;
        ctrl.lui       = 1'b0;
        ctrl.auipc     = 1'b0;
        ctrl.system    = 1'b0;
        ctrl.alu_op    = rv_pkg::ALU_ADD;
        ctrl.imm_type  = rv_pkg::IMM_I;

        if (inst_valid) begin
            case (opcode)
                rv_pkg::OPC_LUI: begin
                    ctrl.reg_write = 1'b1;
                    ctrl.alu_src   = 1'b1;
                    ctrl.imm_type  = rv_pkg::IMM_U;
                    ctrl.alu_op    = rv_pkg::ALU_LUI;
                    ctrl.lui       = 1'b1;
                end
                rv_pkg::OPC_AUIPC: begin
                    ctrl.reg_write = 1'b1;
                    ctrl.alu_src   = 1'b1;
                    ctrl.imm_type  = rv_pkg::IMM_U;
                    ctrl.alu_op    = rv_pkg::ALU_AUIPC;
                    ctrl.auipc     = 1'b1;
                end
                rv_pkg::OPC_JAL: begin
                    ctrl.reg_write = 1'b1;
                    ctrl.jump      = 1'b1;
                    ctrl.alu_src   = 1'b1;
                    ctrl.imm_type  = rv_pkg::IMM_J;
                end
                rv_pkg::OPC_JALR: begin
                    ctrl.reg_write = 1'b1;
                    ctrl.jalr      = 1'b1;
                    ctrl.alu_src   = 1'b1;
                end
                rv_pkg::OPC_BRANCH: begin
                    ctrl.branch   = 1'b1;
                    ctrl.imm_type = rv_pkg::IMM_B;
                    case (funct3)
                        3'b000:  ctrl.alu_op = rv_pkg::ALU_EQ;
                        3'b001:  ctrl.alu_op = rv_pkg::ALU_NE;
                        3'b100:  ctrl.alu_op = rv_pkg::ALU_LT;
                        3'b101:  ctrl.alu_op = rv_pkg::ALU_GE;
                        3'b110:  ctrl.alu_op = rv_pkg::ALU_LTU;
                        3'b111:  ctrl.alu_op = rv_pkg::ALU_GEU;
                        default: ctrl.alu_op = rv_pkg::ALU_EQ;
                    endcase
                end
                rv_pkg::OPC_LOAD: begin
                    ctrl.reg_write = 1'b1;
                    ctrl.mem_read  = 1'b1;
                    ctrl.alu_src   = 1'b1;
                end
                rv_pkg::OPC_STORE: begin
                    ctrl.mem_write = 1'b1;
                    ctrl.alu_src   = 1'b1;
                    ctrl.imm_type  = rv_pkg::IMM_S;
                end
                rv_pkg::OPC_OP_IMM: begin
                    ctrl.reg_write = 1'b1;
                    ctrl.alu_src   = 1'b1;
                    case (funct3)
                        3'b000: ctrl.alu_op = rv_pkg::ALU_ADD;
                        3'b001: ctrl.alu_op = rv_pkg::ALU_SLL;
                        3'b010: ctrl.alu_op = rv_pkg::ALU_SLT;
                        3'b011: ctrl.alu_op = rv_pkg::ALU_SLTU;
                        3'b100: ctrl.alu_op = rv_pkg::ALU_XOR;
                        3'b101: ctrl.alu_op = funct7_b5 ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                        3'b110: ctrl.alu_op = rv_pkg::ALU_OR;
                        3'b111: ctrl.alu_op = rv_pkg::ALU_AND;
                    endcase
                end
                rv_pkg::OPC_OP: begin
                    ctrl.reg_write = 1'b1;
                    case (funct3)
                        3'b000: ctrl.alu_op = funct7_b5 ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
                        3'b001: ctrl.alu_op = rv_pkg::ALU_SLL;
                        3'b010: ctrl.alu_op = rv_pkg::ALU_SLT;
                        3'b011: ctrl.alu_op = rv_pkg::ALU_SLTU;
                        3'b100: ctrl.alu_op = rv_pkg::ALU_XOR;
                        3'b101: ctrl.alu_op = funct7_b5 ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                        3'b110: ctrl.alu_op = rv_pkg::ALU_OR;
                        3'b111: ctrl.alu_op = rv_pkg::ALU_AND;
                    endcase
                end
                rv_pkg::OPC_SYSTEM: begin
                    ctrl.system = 1'b1;
                    if (funct3 != 3'b000) begin
                        ctrl.reg_write = 1'b1;  // CSR ops
                    end
                end
                rv_pkg::OPC_FENCE: begin
                    ctrl.system = 1'b0;  // Plain no-op
                end
                default: begin
                    ctrl.reg_write = 1'b0;
                end
            endcase
        end
    end

    // At most one instruction class may be flagged
    always_comb begin
        assert ($onehot0({ctrl.lui, ctrl.auipc, ctrl.jump, ctrl.jalr,
                          ctrl.branch, ctrl.mem_read, ctrl.mem_write}))
            else $error("control_unit: more than one instruction class decoded");
    end

endmodule

`default_nettype wire

// ==== hdl/imm_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module imm_gen (
    input  logic [31:0]       inst,
    input  rv_pkg::imm_type_e imm_type,
    output logic [31:0]       imm
);

    always_comb begin
        case (imm_type)
            rv_pkg::IMM_I: begin
                imm = {{20{inst[31]}}, inst[31:20]};
            end
            rv_pkg::IMM_S: begin
                imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            end
            rv_pkg::IMM_B: begin
                imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            rv_pkg::IMM_U: begin
                imm = {inst[31:12], 12'd0};
            end
            rv_pkg::IMM_J: begin
                imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            default: begin
                imm = 32'd0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic        clk,
    input  logic        rst,
    input  logic [4:0]  raddr_a,
    input  logic [4:0]  raddr_b,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata,
    output logic [31:0] rdata_a,
    output logic [31:0] rdata_b
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata_a = (raddr_a == 5'd0) ? 32'd0 : regs[raddr_a];  // x0 hardwired
    assign rdata_b = (raddr_b == 5'd0) ? 32'd0 : regs[raddr_b];

    // The retire stage must filter x0 destinations before the write port
    assert property (@(posedge clk) disable iff (rst) we |-> waddr != 5'd0)
        else $error("reg_file: write to x0 requested");

endmodule

`default_nettype wire

// ==== hdl/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  rv_pkg::ctrl_t ctrl,
    input  logic [31:0]   pc,
    input  logic [31:0]   rs1_data,
    input  logic [31:0]   rs2_data,
    input  logic [31:0]   imm,
    output logic [31:0]   result
);

    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [4:0]  shamt;
    logic        lt_s;
    logic        lt_u;
    logic        eq;

    assign op_a  = ctrl.auipc ? pc : rs1_data;
    assign op_b  = ctrl.alu_src ? imm : rs2_data;
    assign shamt = op_b[4:0];
    assign lt_s  = $signed(op_a) < $signed(op_b);
    assign lt_u  = op_a < op_b;
    assign eq    = op_a == op_b;

    always_comb begin
        case (ctrl.alu_op)
            rv_pkg::ALU_ADD:   result = op_a + op_b;
            rv_pkg::ALU_SUB:   result = op_a - op_b;
            rv_pkg::ALU_SLL:   result = op_a << shamt;
            rv_pkg::ALU_SLT:   result = {31'd0, lt_s};
            rv_pkg::ALU_SLTU:  result = {31'd0, lt_u};
            rv_pkg::ALU_XOR:   result = op_a ^ op_b;
            rv_pkg::ALU_SRL:   result = op_a >> shamt;
            rv_pkg::ALU_SRA:   result = $unsigned($signed(op_a) >>> shamt);
            rv_pkg::ALU_OR:    result = op_a | op_b;
            rv_pkg::ALU_AND:   result = op_a & op_b;
            rv_pkg::ALU_LUI:   result = op_b;         // Immediate passes through
            rv_pkg::ALU_AUIPC: result = op_a + op_b;  // op_a is pc here
            rv_pkg::ALU_EQ:    result = {31'd0, eq};
            rv_pkg::ALU_NE:    result = {31'd0, !eq};
            rv_pkg::ALU_LT:    result = {31'd0, lt_s};
            rv_pkg::ALU_GE:    result = {31'd0, !lt_s};
            rv_pkg::ALU_LTU:   result = {31'd0, lt_u};
            rv_pkg::ALU_GEU:   result = {31'd0, !lt_u};
            default:           result = 32'd0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/retire_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module retire_stage (
    input  logic            clk,
    input  logic            rst,
    input  logic            in_valid,
    output logic            in_ready,
    input  logic [31:0]     pc,
    input  rv_pkg::ctrl_t   ctrl,
    input  logic [4:0]      rd,
    input  logic [31:0]     imm,
    input  logic [31:0]     rs1_data,
    input  logic [31:0]     rs2_data,
    input  logic [31:0]     alu_result,
    output logic            out_valid,
    input  logic            out_ready,
    output rv_pkg::retire_t out_rec,
    output logic            rf_we,
    output logic [4:0]      rf_waddr,
    output logic [31:0]     rf_wdata
);

    logic            accept;
    logic            taken;
    logic            rd_we;
    logic [31:0]     pc_plus4;
    logic [31:0]     pc_rel;
    logic [31:0]     jalr_sum;
    logic [31:0]     next_pc;
    logic [31:0]     rd_data;
    rv_pkg::retire_t rec_d;

    assign in_ready = !out_valid || out_ready;  // Empty or draining
    assign accept   = in_valid && in_ready;

    assign pc_plus4 = pc + 32'd4;
    assign pc_rel   = pc + imm;
    assign jalr_sum = rs1_data + imm;
    assign taken    = ctrl.branch && alu_result[0];

    assign next_pc = ctrl.jalr ? {jalr_sum[31:1], 1'b0} :
                     (ctrl.jump || taken) ? pc_rel : pc_plus4;

    assign rd_data = (ctrl.jump || ctrl.jalr) ? pc_plus4 : alu_result;
    // No CSR file, so SYSTEM never writes rd
    assign rd_we   = ctrl.reg_write && !ctrl.mem_read && !ctrl.system && (rd != 5'd0);

    always_comb begin
        rec_d.pc         = pc;
        rec_d.next_pc    = next_pc;
        rec_d.rd         = rd;
        rec_d.rd_we      = rd_we;
        rec_d.rd_data    = rd_data;
        rec_d.mem_read   = ctrl.mem_read;
        rec_d.mem_write  = ctrl.mem_write;
        rec_d.mem_addr   = alu_result;
        rec_d.store_data = rs2_data;
        rec_d.taken      = taken;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (accept) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_rec <= rec_d;
        end
    end

    assign rf_we    = accept && rd_we;  // Same edge as record load
    assign rf_waddr = rd;
    assign rf_wdata = rd_data;

    assert property (@(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_rec)))
        else $error("retire_stage: record changed under back-pressure");

endmodule

`default_nettype wire

// ==== hdl/exec_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_core (
    input  logic            clk,
    input  logic            rst,
    input  logic            in_valid,
    output logic            in_ready,
    input  logic [31:0]     in_inst,
    input  logic [31:0]     in_pc,
    output logic            out_valid,
    input  logic            out_ready,
    output rv_pkg::retire_t out_rec
);

    rv_pkg::ctrl_t ctrl;
    logic [4:0]    rd;
    logic [4:0]    rs1;
    logic [4:0]    rs2;
    logic [31:0]   imm;
    logic [31:0]   rs1_data;
    logic [31:0]   rs2_data;
    logic [31:0]   alu_result;
    logic          rf_we;
    logic [4:0]    rf_waddr;
    logic [31:0]   rf_wdata;

    control_unit u_ctrl (
        .inst       (in_inst),
        .inst_valid (in_valid),
        .ctrl       (ctrl),
        .rd         (rd),
        .rs1        (rs1),
        .rs2        (rs2),
        .funct3     ()          // Carried by the ALU op
    );

    imm_gen u_imm (
        .inst     (in_inst),
        .imm_type (ctrl.imm_type),
        .imm      (imm)
    );

    reg_file u_rf (
        .clk     (clk),
        .rst     (rst),
        .raddr_a (rs1),
        .raddr_b (rs2),
        .we      (rf_we),
        .waddr   (rf_waddr),
        .wdata   (rf_wdata),
        .rdata_a (rs1_data),
        .rdata_b (rs2_data)
    );

    alu u_alu (
        .ctrl     (ctrl),
        .pc       (in_pc),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .imm      (imm),
        .result   (alu_result)
    );

    retire_stage u_retire (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .pc         (in_pc),
        .ctrl       (ctrl),
        .rd         (rd),
        .imm        (imm),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .alu_result (alu_result),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_rec    (out_rec),
        .rf_we      (rf_we),
        .rf_waddr   (rf_waddr),
        .rf_wdata   (rf_wdata)
    );

endmodule

`default_nettype wire

// ==== dv/tb_exec_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_exec_core;

    localparam int TIMEOUT = 64;  // Cycles allowed per wait loop

    logic            clk;
    logic            rst;
    logic            in_valid;
    logic            in_ready;
    logic [31:0]     in_inst;
    logic [31:0]     in_pc;
    logic            out_valid;
    logic            out_ready;
    rv_pkg::retire_t out_rec;

    logic [31:0]     lfsr;
    logic [31:0]     shadow [32];
    logic [31:0]     cur_pc;
    logic            heavy_bp;
    logic            aborted;
    rv_pkg::retire_t exp_q [$];
    int              checks;
    int              errors;
    int              records;
    int              tests;
    int              tests_failed;
    int              err_mark;
    int              rec_mark;

    exec_core UUT (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_inst   (in_inst),
        .in_pc     (in_pc),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_rec   (out_rec)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // Galois form with taps 32 22 2 1
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return v;
    endfunction

    // Small register pool so results feed later instructions
    function automatic logic [4:0] pick_reg();
        logic [31:0] r;
        r = rand_bits(3);
        case (r[2:0])
            3'd0: return 5'd0;
            3'd1: return 5'd1;
            3'd2: return 5'd2;
            3'd3: return 5'd3;
            3'd4: return 5'd5;
            3'd5: return 5'd8;
            3'd6: return 5'd13;
            default: return 5'd31;
        endcase
    endfunction

    // Class 0 OP, 1 OP-IMM, 2 LUI, 3 AUIPC, 4 JAL, 5 JALR, 6 BRANCH,
    // 7 LOAD, 8 STORE, 9 SYSTEM, 10 FENCE
    function automatic logic [31:0] gen_inst(input int cls);
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [11:0] imm12;
        r     = rand_bits(32);
        rd    = pick_reg();
        rs1   = pick_reg();
        rs2   = pick_reg();
        f3    = r[14:12];
        imm12 = r[11:0];
        case (cls)
            0: return {1'b0, (f3 == 3'd0 || f3 == 3'd5) ? r[20] : 1'b0, 5'd0,
                       rs2, rs1, f3, rd, 7'b0110011};
            1: begin
                if (f3 == 3'd1) begin
                    imm12 = {7'd0, r[4:0]};
                end else if (f3 == 3'd5) begin
                    imm12 = {1'b0, r[20], 5'd0, r[4:0]};  // SRLI or SRAI
                end
                return {imm12, rs1, f3, rd, 7'b0010011};
            end
            2: return {r[31:12], rd, 7'b0110111};
            3: return {r[31:12], rd, 7'b0010111};
            4: return {r[31:12], rd, 7'b1101111};
            5: return {imm12, rs1, 3'b000, rd, 7'b1100111};
            6: begin
                if (f3 == 3'd2 || f3 == 3'd3) begin
                    f3 = f3 + 3'd4;  // No branch on 010 or 011
                end
                return {r[11:5], rs2, rs1, f3, r[4:0], 7'b1100011};
            end
            7: return {imm12, rs1, f3, rd, 7'b0000011};
            8: return {r[11:5], rs2, rs1, f3, r[4:0], 7'b0100011};
            9: return {imm12, rs1, f3, rd, 7'b1110011};
            default: return {imm12, rs1, f3, rd, 7'b0001111};
        endcase
    endfunction

    function automatic logic [31:0] alu_calc(input logic [2:0] f3, input logic alt,
                                             input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'd0, $signed(a) < $signed(b)};
            3'd3: return {31'd0, a < b};
            3'd4: return a ^ b;
            3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [31:0] branch_cmp(input logic [2:0] f3,
                                               input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd1: return {31'd0, a != b};
            3'd4: return {31'd0, $signed(a) < $signed(b)};
            3'd5: return {31'd0, $signed(a) >= $signed(b)};
            3'd6: return {31'd0, a < b};
            3'd7: return {31'd0, a >= b};
            default: return {31'd0, a == b};
        endcase
    endfunction

    // Expected record of one accepted instruction and its shadow register update
    function automatic rv_pkg::retire_t model_inst(input logic [31:0] inst,
                                                   input logic [31:0] pc);
        rv_pkg::retire_t r;
        logic [31:0]     a;
        logic [31:0]     b;
        logic [31:0]     res;
        logic [31:0]     imm_i;
        logic [31:0]     imm_s;
        logic [31:0]     imm_b;
        logic [31:0]     imm_u;
        logic [31:0]     imm_j;
        logic            wr;
        logic            link;
        a     = shadow[inst[19:15]];
        b     = shadow[inst[24:20]];
        imm_i = {{20{inst[31]}}, inst[31:20]};
        imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        imm_u = {inst[31:12], 12'd0};
        imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        wr    = 1'b0;
        link  = 1'b0;
        r            = '0;
        r.pc         = pc;
        r.rd         = inst[11:7];
        r.next_pc    = pc + 32'd4;
        r.store_data = b;
        case (inst[6:0])
            7'b0110111: begin
                res = imm_u;
                wr  = 1'b1;
            end
            7'b0010111: begin
                res = pc + imm_u;
                wr  = 1'b1;
            end
            7'b1101111: begin
                res       = a + imm_j;  // ALU still adds rs1 field value
                r.next_pc = pc + imm_j;
                wr        = 1'b1;
                link      = 1'b1;
            end
            7'b1100111: begin
                res       = a + imm_i;
                r.next_pc = {res[31:1], 1'b0};
                wr        = 1'b1;
                link      = 1'b1;
            end
            7'b1100011: begin
                res     = branch_cmp(inst[14:12], a, b);
                r.taken = res[0];
                if (res[0]) begin
                    r.next_pc = pc + imm_b;
                end
            end
            7'b0000011: begin
                res        = a + imm_i;
                r.mem_read = 1'b1;
            end
            7'b0100011: begin
                res         = a + imm_s;
                r.mem_write = 1'b1;
            end
            7'b0010011: begin
                res = alu_calc(inst[14:12], inst[30] && inst[14:12] == 3'd5, a, imm_i);
                wr  = 1'b1;
            end
            7'b0110011: begin
                res = alu_calc(inst[14:12], inst[30], a, b);
                wr  = 1'b1;
            end
            default: begin
                res = a + b;  // SYSTEM and FENCE
            end
        endcase
        r.rd_data  = link ? pc + 32'd4 : res;
        r.rd_we    = wr && (r.rd != 5'd0);
        r.mem_addr = res;
        if (r.rd_we) begin
            shadow[r.rd] = r.rd_data;
        end
        return r;
    endfunction

    task automatic report_field(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR out_rec.%s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_rec(input rv_pkg::retire_t got, input rv_pkg::retire_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            report_field("pc", got.pc, exp.pc);
            report_field("next_pc", got.next_pc, exp.next_pc);
            report_field("rd", 32'(got.rd), 32'(exp.rd));
            report_field("rd_we", 32'(got.rd_we), 32'(exp.rd_we));
            report_field("rd_data", got.rd_data, exp.rd_data);
            report_field("mem_read", 32'(got.mem_read), 32'(exp.mem_read));
            report_field("mem_write", 32'(got.mem_write), 32'(exp.mem_write));
            report_field("mem_addr", got.mem_addr, exp.mem_addr);
            report_field("store_data", got.store_data, exp.store_data);
            report_field("taken", 32'(got.taken), 32'(exp.taken));
        end
    endtask

    task automatic check_ready(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // One clock cycle of stimulus and checking
    task automatic step(input logic offer, input logic [31:0] inst, output logic accepted);
        logic [31:0]     r;
        logic            busy;
        rv_pkg::retire_t rec;
        @(negedge clk);
        r         = rand_bits(2);
        in_valid  = offer;
        in_inst   = inst;
        in_pc     = cur_pc;
        out_ready = heavy_bp ? r[0] : (r[1] | r[0]);
        #1;
        busy = exp_q.size() != 0;
        check_ready("out_valid", out_valid, busy);
        check_ready("in_ready", in_ready, !busy || out_ready);
        if (busy && out_valid) begin
            check_rec(out_rec, exp_q[0]);  // Also catches changes while held
        end
        if (busy && out_valid && out_ready) begin
            void'(exp_q.pop_front());
            records++;
        end
        accepted = offer && in_ready;
        if (accepted) begin
            rec = model_inst(inst, cur_pc);
            exp_q.push_back(rec);
            cur_pc = rec.next_pc;
        end
    endtask

    task automatic issue(input logic [31:0] inst);
        logic [31:0] r;
        logic        acc;
        int          n;
        acc = 1'b0;
        n   = 0;
        while (!acc && !aborted) begin
            if (n == TIMEOUT) begin
                $display("Timeout: instruction %h was never accepted", inst);
                errors++;
                aborted = 1'b1;
            end else begin
                r = rand_bits(2);
                step(r[1] | r[0], inst, acc);
                n++;
            end
        end
    endtask

    task automatic drain();
        logic acc;
        int   n;
        n = 0;
        while (exp_q.size() != 0 && !aborted) begin
            if (n == TIMEOUT) begin
                $display("Timeout: retire stream did not drain");
                errors++;
                aborted = 1'b1;
            end else begin
                step(1'b0, in_inst, acc);
                n++;
            end
        end
    endtask

    task automatic test_begin();
        err_mark = errors;
        rec_mark = records;
    endtask

    task automatic test_end(input int num, input string name);
        drain();
        tests++;
        if (errors == err_mark && !aborted) begin
            $display("test %0d %s: %0d records, ok", num, name, records - rec_mark);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d records, %0d errors", num, name,
                     records - rec_mark, errors - err_mark);
        end
    endtask

    initial begin
        logic [31:0] r;
        int          cls;
        lfsr         = 32'hd68d_806a;
        cur_pc       = 32'h0000_1000;
        heavy_bp     = 1'b0;
        aborted      = 1'b0;
        checks       = 0;
        errors       = 0;
        records      = 0;
        tests        = 0;
        tests_failed = 0;
        for (int i = 0; i < 32; i++) begin
            shadow[i] = 32'd0;
        end
        rst       = 1'b1;
        in_valid  = 1'b0;
        in_inst   = 32'd0;
        in_pc     = 32'd0;
        out_ready = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        test_begin();
        @(negedge clk);
        #1;
        check_ready("out_valid", out_valid, 1'b0);
        check_ready("in_ready", in_ready, 1'b1);
        for (int i = 0; i < 4; i++) begin
            r = rand_bits(12);
            issue({r[11:0], pick_reg(), 3'b000, pick_reg(), 7'b0010011});  // ADDI
        end
        test_end(1, "reset_addi");

        test_begin();
        for (int i = 0; i < 60; i++) begin
            r = rand_bits(1);
            issue(gen_inst(r[0] ? 0 : 1));
        end
        test_end(2, "alu_ops");

        test_begin();
        for (int i = 0; i < 32; i++) begin
            r = rand_bits(2);
            issue(gen_inst(2 + int'(r[1:0])));
        end
        test_end(3, "upper_and_jumps");

        test_begin();
        for (int i = 0; i < 40; i++) begin
            r = rand_bits(2);
            issue(gen_inst((r[1:0] == 2'd0) ? 1 : 6));  // Some OP-IMM mixed in
        end
        test_end(4, "branches");

        test_begin();
        for (int i = 0; i < 40; i++) begin
            r = rand_bits(2);
            issue(gen_inst(7 + int'(r[1:0])));
        end
        test_end(5, "mem_and_system");

        test_begin();
        heavy_bp = 1'b1;
        for (int i = 0; i < 80; i++) begin
            r   = rand_bits(4);
            cls = int'(r[3:0]) % 11;
            issue(gen_inst(cls));
        end
        test_end(6, "back_pressure");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
hdl/rv_pkg.sv
hdl/control_unit.sv
hdl/imm_gen.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/retire_stage.sv
hdl/exec_core.sv
dv/tb_exec_core.sv

// ==== Makefile ====
TOP := tb_exec_core

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf obj_dir
